/* verilog/clkrst_pkg.sv */
// clkrst_pkg
// shared sizes, register map, vector types and stage structs for the
// multi-link fc clock/reset block

package clkrst_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int N_LINKS     = 4;
  localparam int N_CHAN      = 2 * N_LINKS;   // two serdes channels per link
  localparam int DATA_W      = 32;
  localparam int ADDR_W      = 4;
  localparam int SYNC_STAGES = 2;             // release depth of synchronizers

  // vectors with a meaning of their own
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [N_LINKS-1:0] link_vec_t;     // one bit per link
  typedef logic [N_CHAN-1:0]  chan_vec_t;     // [2l] = link l chan 0, [2l+1] = chan 1

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////
  localparam addr_t ADDR_RSTCTRL0  = 4'd0;
  localparam addr_t ADDR_RSTCTRL1  = 4'd1;
  localparam addr_t ADDR_RSTSTATUS = 4'd2;    // read only

  localparam int RST0_CHIP_BIT  = 0;          // self clearing
  localparam int RST0_LINK_LSB  = 4;
  localparam int RST1_CORE_LSB  = 0;
  localparam int RST1_TX_LSB    = RST1_CORE_LSB + N_LINKS;
  localparam int RST1_RX_LSB    = RST1_TX_LSB + N_LINKS;   // spare field follows
  localparam int STAT_PLL_BIT   = 0;
  localparam int STAT_RXRDY_LSB = 8;

  ////////////////////////////////////////////////////////////////////////////
  // stage to stage bundles
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic  wr_en;
    logic  rd_en;
    addr_t addr;
    data_t wr_data;
  } mm_req_t;

  // software controls, active high
  typedef struct packed {
    logic      chip_rst;
    link_vec_t link_rst;
    link_vec_t link_core_rst;
    link_vec_t link_tx_rst;
    link_vec_t link_rx_rst;
  } rst_ctrl_t;

  // raw requests before the synchronizers, active low
  typedef struct packed {
    logic      core_n;
    link_vec_t link_core_n;
    chan_vec_t chan_tx_n;
    chan_vec_t chan_rx_n;
  } rst_req_t;

endpackage

/* verilog/clkrst_regs.sv */
// clkrst_regs
// reset control registers on the simple mm bus: link masks, a self
// clearing chip reset and a live status word, read back two cycles later

`timescale 1ns/10ps

module clkrst_regs
(
  input  logic                  iCLK_SERDES_RXREC,
  input  logic                  rst_n,
  input  clkrst_pkg::mm_req_t   mm_req,
  output clkrst_pkg::data_t     rd_data,
  output logic                  rd_data_v,
  input  logic                  pll_locked,
  input  clkrst_pkg::chan_vec_t rx_ready_sticky,
  output clkrst_pkg::rst_ctrl_t rst_ctrl
);

  import clkrst_pkg::*;

  logic                 chip_rst;          // one cycle pulse
  link_vec_t            link_rst;          // rstctrl0 link field
  logic [4*N_LINKS-1:0] rstctrl1;          // core, tx, rx, spare
  logic                 wr_ctrl0;
  logic                 wr_ctrl1;
  data_t                rd_mux;
  data_t                rd_hold;           // contents at the sampling edge
  logic                 rd_pend;

  assign wr_ctrl0 = mm_req.wr_en && (mm_req.addr == ADDR_RSTCTRL0);
  assign wr_ctrl1 = mm_req.wr_en && (mm_req.addr == ADDR_RSTCTRL1);

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge iCLK_SERDES_RXREC or negedge rst_n)
  begin
    if (!rst_n)
    begin
      chip_rst <= 1'b0;
      link_rst <= '0;
      rstctrl1 <= '0;
    end
    else
    begin
      // only set by a write, drops on the next edge
      chip_rst <= wr_ctrl0 && mm_req.wr_data[RST0_CHIP_BIT];
      if (wr_ctrl0)
        link_rst <= mm_req.wr_data[RST0_LINK_LSB +: N_LINKS];
      if (wr_ctrl1)
        rstctrl1 <= mm_req.wr_data[4*N_LINKS-1:0];
    end
  end

  assign rst_ctrl.chip_rst      = chip_rst;
  assign rst_ctrl.link_rst      = link_rst;
  assign rst_ctrl.link_core_rst = rstctrl1[RST1_CORE_LSB +: N_LINKS];
  assign rst_ctrl.link_tx_rst   = rstctrl1[RST1_TX_LSB +: N_LINKS];
  assign rst_ctrl.link_rx_rst   = rstctrl1[RST1_RX_LSB +: N_LINKS];

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    rd_mux = '0;                       // unmapped reads 0
    case (mm_req.addr)
      ADDR_RSTCTRL0:
      begin
        rd_mux[RST0_CHIP_BIT]              = chip_rst;
        rd_mux[RST0_LINK_LSB +: N_LINKS]   = link_rst;
      end
      ADDR_RSTCTRL1:
        rd_mux[4*N_LINKS-1:0]              = rstctrl1;
      ADDR_RSTSTATUS:
      begin
        rd_mux[STAT_PLL_BIT]               = pll_locked;   // live, not latched
        rd_mux[STAT_RXRDY_LSB +: N_CHAN]   = rx_ready_sticky;
      end
      default: ;
    endcase
  end

  // valid pipe, two stages
  always_ff @(posedge iCLK_SERDES_RXREC or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_pend   <= 1'b0;
      rd_data_v <= 1'b0;
    end
    else
    begin
      rd_pend   <= mm_req.rd_en;
      rd_data_v <= rd_pend;        // one cycle pulse per read
    end
  end

  // data pipe follows valid
  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (mm_req.rd_en)
      rd_hold <= rd_mux;
    if (rd_pend)
      rd_data <= rd_hold;
  end

endmodule

/* verilog/rst_request_combine.sv */
// rst_request_combine
// merges pad reset, register controls and pll locks into raw active low
// reset requests per domain, one register stage

`timescale 1ns/10ps

module rst_request_combine
(
  input  logic                  iCLK_SERDES_RXREC,
  input  logic                  rst_n,
  input  logic                  uc_rst_pad_n,
  input  logic                  pll_locked,
  input  clkrst_pkg::chan_vec_t atx_pll_locked,
  input  clkrst_pkg::rst_ctrl_t rst_ctrl,
  output clkrst_pkg::rst_req_t  rst_req
);

  import clkrst_pkg::*;

  logic     chip_ok;       // pad released and no chip reset
  rst_req_t req_d;

  assign chip_ok = uc_rst_pad_n & ~rst_ctrl.chip_rst;

  ////////////////////////////////////////////////////////////////////////////
  // request rules
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    req_d.core_n = chip_ok & pll_locked;

    for (int l = 0; l < N_LINKS; l++)
    begin
      req_d.link_core_n[l] = chip_ok & pll_locked
                           & ~rst_ctrl.link_rst[l]
                           & ~rst_ctrl.link_core_rst[l];
    end

    // each link's controls fan out to both of its channels
    for (int c = 0; c < N_CHAN; c++)
    begin
      req_d.chan_tx_n[c] = chip_ok
                         & ~rst_ctrl.link_rst[c/2]
                         & ~rst_ctrl.link_tx_rst[c/2]
                         & atx_pll_locked[c];          // tx needs its atx pll
      req_d.chan_rx_n[c] = chip_ok
                         & ~rst_ctrl.link_rst[c/2]
                         & ~rst_ctrl.link_rx_rst[c/2]; // rx ignores locks
    end
  end

  // all requests held active while rst_n is low
  always_ff @(posedge iCLK_SERDES_RXREC or negedge rst_n)
  begin
    if (!rst_n)
      rst_req <= '0;
    else
      rst_req <= req_d;
  end

endmodule

/* verilog/rst_sync_release.sv */
// rst_sync_release
// bank of reset synchronizers, each bit asserts as soon as its request
// drops and releases SYNC_STAGES cycles after the request rises

`timescale 1ns/10ps

module rst_sync_release
#(
  parameter int WIDTH = 1
)
(
  input  logic             iCLK_SERDES_RXREC,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] req_n,
  output logic [WIDTH-1:0] rst_out_n
);

  import clkrst_pkg::*;

  logic [WIDTH-1:0] clr_n;   // async clear per bit

  assign clr_n = req_n & {WIDTH{rst_n}};

  ////////////////////////////////////////////////////////////////////////////
  // one flop chain per bit
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < WIDTH; i++)
  begin : g_bit
    logic [SYNC_STAGES-1:0] chain;

    always_ff @(posedge iCLK_SERDES_RXREC or negedge clr_n[i])
    begin
      if (!clr_n[i])
        chain <= '0;                               // assert at once
      else
        chain <= {chain[SYNC_STAGES-2:0], 1'b1};   // walk a one out
    end

    assign rst_out_n[i] = chain[SYNC_STAGES-1];
  end

endmodule

/* verilog/rx_ready_tracker.sv */
// rx_ready_tracker
// sticky per channel rx_ready, set on first assertion and held
// through cdr flapping until the channel rx reset clears it

`timescale 1ns/10ps

module rx_ready_tracker
(
  input  logic                  iCLK_SERDES_RXREC,
  input  clkrst_pkg::chan_vec_t rx_ready,
  input  clkrst_pkg::chan_vec_t rst_chan_rx_n,
  output clkrst_pkg::chan_vec_t rx_ready_sticky
);

  import clkrst_pkg::*;

  // without a receive signal rx_ready may toggle, so only reset clears
  for (genvar c = 0; c < N_CHAN; c++)
  begin : g_chan
    logic sticky;

    always_ff @(posedge iCLK_SERDES_RXREC or negedge rst_chan_rx_n[c])
    begin
      if (!rst_chan_rx_n[c])
        sticky <= 1'b0;
      else if (rx_ready[c])
        sticky <= 1'b1;   // set once
    end

    assign rx_ready_sticky[c] = sticky;
  end

endmodule

/* verilog/clkrst_top.sv */
// clkrst_top
// reset management for a 4 link fc block: registers, request combine,
// release synchronizers and the sticky rx-ready flags

`timescale 1ns/10ps

module clkrst_top
(
  input  logic                  iCLK_SERDES_RXREC,
  input  logic                  rst_n,
  input  logic                  uc_rst_pad_n,
  input  clkrst_pkg::mm_req_t   mm_req,
  output clkrst_pkg::data_t     rd_data,
  output logic                  rd_data_v,
  input  logic                  pll_locked,
  input  clkrst_pkg::chan_vec_t atx_pll_locked,
  input  clkrst_pkg::chan_vec_t rx_ready,
  output logic                  rst_core_n,
  output clkrst_pkg::link_vec_t rst_link_core_n,
  output clkrst_pkg::chan_vec_t rst_chan_tx_n,
  output clkrst_pkg::chan_vec_t rst_chan_rx_n
);

  import clkrst_pkg::*;

  rst_ctrl_t rst_ctrl;          // regs -> combine
  rst_req_t  rst_req;           // combine -> synchronizers
  chan_vec_t rx_ready_sticky;   // tracker -> status reg

  ////////////////////////////////////////////////////////////////////////////
  // registers and request combine
  ////////////////////////////////////////////////////////////////////////////
  clkrst_regs u_regs (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rst_n             (rst_n),
    .mm_req            (mm_req),
    .rd_data           (rd_data),
    .rd_data_v         (rd_data_v),
    .pll_locked        (pll_locked),
    .rx_ready_sticky   (rx_ready_sticky),
    .rst_ctrl          (rst_ctrl)
  );

  rst_request_combine u_combine (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rst_n             (rst_n),
    .uc_rst_pad_n      (uc_rst_pad_n),
    .pll_locked        (pll_locked),
    .atx_pll_locked    (atx_pll_locked),
    .rst_ctrl          (rst_ctrl),
    .rst_req           (rst_req)
  );

  ////////////////////////////////////////////////////////////////////////////
  // release synchronizers, one bank per domain
  ////////////////////////////////////////////////////////////////////////////
  rst_sync_release #(.WIDTH(1)) u_sync_core (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rst_n             (rst_n),
    .req_n             (rst_req.core_n),
    .rst_out_n         (rst_core_n)
  );

  rst_sync_release #(.WIDTH(N_LINKS)) u_sync_link_core (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rst_n             (rst_n),
    .req_n             (rst_req.link_core_n),
    .rst_out_n         (rst_link_core_n)
  );

  rst_sync_release #(.WIDTH(N_CHAN)) u_sync_tx (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rst_n             (rst_n),
    .req_n             (rst_req.chan_tx_n),
    .rst_out_n         (rst_chan_tx_n)
  );

  rst_sync_release #(.WIDTH(N_CHAN)) u_sync_rx (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rst_n             (rst_n),
    .req_n             (rst_req.chan_rx_n),
    .rst_out_n         (rst_chan_rx_n)
  );

  // sticky flags cleared by the synchronized rx reset
  rx_ready_tracker u_rx_ready (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rx_ready          (rx_ready),
    .rst_chan_rx_n     (rst_chan_rx_n),
    .rx_ready_sticky   (rx_ready_sticky)
  );

endmodule

/* test/tb_clkrst.sv */
// tb_clkrst
// random register writes, lock toggling, chip reset and rx-ready checks
// against a shadow model of the reset request rules

`timescale 1ns/10ps

module tb_clkrst;

  import clkrst_pkg::*;

  logic      iCLK_SERDES_RXREC;
  logic      rst_n;
  logic      uc_rst_pad_n;
  mm_req_t   mm_req;
  data_t     rd_data;
  logic      rd_data_v;
  logic      pll_locked;
  chan_vec_t atx_pll_locked;
  chan_vec_t rx_ready;
  logic      rst_core_n;
  link_vec_t rst_link_core_n;
  chan_vec_t rst_chan_tx_n;
  chan_vec_t rst_chan_rx_n;

  data_t     sh_ctrl0;     // link bits only, chip bit never sticks
  data_t     sh_ctrl1;
  chan_vec_t sh_sticky;
  data_t     wdat;
  chan_vec_t mask;
  link_vec_t lnk;
  int        lnk_idx;

  clkrst_top u_clkrst_top (.*);

  initial
  begin
    iCLK_SERDES_RXREC = 1'b0;
    forever #10 iCLK_SERDES_RXREC = ~iCLK_SERDES_RXREC;
  end

  // whole run limit
  initial
  begin
    repeat (20000) @(posedge iCLK_SERDES_RXREC);
    $display("run limit reached without finishing");
    $display("Simulation FAILED");
    $fatal(1);
  end

  task automatic report_failure(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // reset outputs from the request rules, packed core/link/tx/rx
  function automatic logic [20:0] expected_resets();
    logic      ok;
    link_vec_t lr;
    link_vec_t lcore;
    chan_vec_t tx;
    chan_vec_t rx;
    ok = uc_rst_pad_n;
    for (int l = 0; l < N_LINKS; l++)
      lcore[l] = ok & pll_locked & ~sh_ctrl0[4+l] & ~sh_ctrl1[l];
    for (int c = 0; c < N_CHAN; c++)
    begin
      lr[c/2] = sh_ctrl0[4+c/2];
      tx[c] = ok & ~lr[c/2] & ~sh_ctrl1[4+c/2] & atx_pll_locked[c];
      rx[c] = ok & ~lr[c/2] & ~sh_ctrl1[8+c/2];
    end
    return {ok & pll_locked, lcore, tx, rx};
  endfunction

  function automatic logic [20:0] observed_resets();
    return {rst_core_n, rst_link_core_n, rst_chan_tx_n, rst_chan_rx_n};
  endfunction

  // let changes pass through all stages, then sample mid-cycle
  task automatic settle_and_compare(input int n);
    repeat (n) @(posedge iCLK_SERDES_RXREC);
    @(negedge iCLK_SERDES_RXREC);
    assert (observed_resets() == expected_resets())
    else report_failure($sformatf("resets %h expected %h",
                                  observed_resets(), expected_resets()));
  endtask

  task automatic bus_write(input addr_t a, input data_t d);
    @(posedge iCLK_SERDES_RXREC);
    mm_req.wr_en   <= 1'b1;
    mm_req.addr    <= a;
    mm_req.wr_data <= d;
    @(posedge iCLK_SERDES_RXREC);
    mm_req.wr_en   <= 1'b0;
    if (a == ADDR_RSTCTRL0)
      sh_ctrl0 = {24'd0, d[7:4], 4'd0};
    else if (a == ADDR_RSTCTRL1)
      sh_ctrl1 = {16'd0, d[15:0]};
  endtask

  task automatic bus_read(input addr_t a, output data_t d);
    int t;
    @(posedge iCLK_SERDES_RXREC);
    mm_req.rd_en <= 1'b1;
    mm_req.addr  <= a;
    @(posedge iCLK_SERDES_RXREC);
    mm_req.rd_en <= 1'b0;
    t = 0;
    @(negedge iCLK_SERDES_RXREC);
    while (!rd_data_v)
    begin
      t++;
      if (t > 8)
        report_failure("read valid never came");
      @(negedge iCLK_SERDES_RXREC);
    end
    d = rd_data;
    @(negedge iCLK_SERDES_RXREC);
    assert (!rd_data_v) else report_failure("read valid longer than one cycle");
  endtask

  task automatic read_and_compare(input addr_t a, input data_t exp);
    data_t v;
    bus_read(a, v);
    assert (v == exp)
    else report_failure($sformatf("addr %0d read %h expected %h", a, v, exp));
  endtask

  initial
  begin
    void'($urandom(32'h916b88fd));
    rst_n = 1'b0;
    uc_rst_pad_n = 1'b1;
    mm_req = '0;
    pll_locked = 1'b1;
    atx_pll_locked = '1;
    rx_ready = '0;
    sh_ctrl0 = '0;
    sh_ctrl1 = '0;
    sh_sticky = '0;
    repeat (4) @(posedge iCLK_SERDES_RXREC);
    rst_n <= 1'b1;

    //////////////////////////////////////////////////////////////////////////
    // 1. release from reset
    //////////////////////////////////////////////////////////////////////////
    for (int i = 0; i < 4; i++)
    begin
      @(negedge iCLK_SERDES_RXREC);
      if (i < 3)
        assert (observed_resets() == '0) else report_failure("early release");
      else
        assert (observed_resets() == '1) else report_failure("no release");
    end

    // 2. random control writes and readback
    for (int i = 0; i < 20; i++)
    begin
      wdat = $urandom & 32'hffff_fffe;   // chip bit left alone here
      bus_write((i % 2) ? ADDR_RSTCTRL1 : ADDR_RSTCTRL0, wdat);
      settle_and_compare(4);
    end
    read_and_compare(ADDR_RSTCTRL0, sh_ctrl0);
    read_and_compare(ADDR_RSTCTRL1, sh_ctrl1);

    // 3. lock toggling
    for (int i = 0; i < 10; i++)
    begin
      @(posedge iCLK_SERDES_RXREC);
      pll_locked     <= 1'($urandom % 2);
      atx_pll_locked <= chan_vec_t'($urandom);
      @(posedge iCLK_SERDES_RXREC);
      @(negedge iCLK_SERDES_RXREC);
      assert ((observed_resets() & ~expected_resets()) == '0)
      else report_failure("lock loss did not assert reset at once");
      settle_and_compare(4);
      @(posedge iCLK_SERDES_RXREC);
      pll_locked     <= 1'b1;
      atx_pll_locked <= '1;
      settle_and_compare(4);
    end

    // 4. chip reset pulse
    bus_write(ADDR_RSTCTRL1, 32'd0);
    bus_write(ADDR_RSTCTRL0, 32'd1);
    @(posedge iCLK_SERDES_RXREC);          // combine stage takes the pulse
    @(negedge iCLK_SERDES_RXREC);
    assert (observed_resets() == '0) else report_failure("chip reset missed");
    read_and_compare(ADDR_RSTCTRL0, 32'd0);
    settle_and_compare(1);

    // 5. sticky rx-ready
    lnk_idx = $urandom % N_LINKS;
    lnk = link_vec_t'(1 << lnk_idx);
    mask = chan_vec_t'($urandom);
    mask[2*lnk_idx +: 2] = 2'b11;                         // flags to be cleared
    mask[2*((lnk_idx + 1) % N_LINKS)] = 1'b1;            // one that must survive
    @(posedge iCLK_SERDES_RXREC);
    rx_ready <= mask;
    @(posedge iCLK_SERDES_RXREC);
    rx_ready <= '0;
    sh_sticky = mask;
    repeat (3) @(posedge iCLK_SERDES_RXREC);
    read_and_compare(ADDR_RSTSTATUS, {16'd0, sh_sticky, 8'd1});
    bus_write(ADDR_RSTCTRL1, {20'd0, lnk, 8'd0});
    for (int c = 0; c < N_CHAN; c++)
      if (lnk[c/2])
        sh_sticky[c] = 1'b0;
    settle_and_compare(4);
    read_and_compare(ADDR_RSTSTATUS, {16'd0, sh_sticky, 8'd1});

    // 6. unmapped addresses
    for (int a = 3; a < 16; a++)
      read_and_compare(addr_t'(a), 32'd0);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* sim.f */
verilog/clkrst_pkg.sv
verilog/clkrst_regs.sv
verilog/rst_request_combine.sv
verilog/rst_sync_release.sv
verilog/rx_ready_tracker.sv
verilog/clkrst_top.sv
test/tb_clkrst.sv

/* Makefile */
# Verilator build and run for the clock/reset block

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_clkrst
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
